// File: design/bitstream_pkg.sv
package bitstream_pkg;

    // ************************************************************************
    // Stream storage. The first bit written sits in the most significant bit.
    // ************************************************************************
    localparam int max_bits = 128;

    typedef logic [max_bits-1:0] code_t;
    typedef logic [7:0]          len_t;

    typedef struct packed {
        code_t code;
        len_t  len;
        logic  overflow;
    } stream_t;

    // A single code word, right-aligned in bits.
    typedef struct packed {
        logic [31:0] bits;
        logic [5:0]  len;
    } vlc_t;

    // Unsigned Exp-Golomb: n leading zeros, then value + 1 in n + 1 bits.
    function automatic vlc_t ue_code(input logic [14:0] value);
        vlc_t        r;
        logic [15:0] x;
        int          n;
        x = 16'(value) + 16'd1;
        n = 0;
        for (int i = 0; i < 16; i++) begin
            if (x[i]) begin
                n = i;
            end
        end
        r.bits = 32'(x);
        r.len  = 6'(2 * n + 1);
        return r;
    endfunction

    // Signed Exp-Golomb maps 1, -1, 2, -2 ... onto code numbers 1, 2, 3, 4 ...
    function automatic vlc_t se_code(input logic signed [7:0] level);
        logic signed [15:0] v;
        logic [14:0]        code_num;
        v = {{8{level[7]}}, level};
        if (v > 0) begin
            code_num = 15'(2 * v - 1);
        end else begin
            code_num = 15'(-2 * v);
        end
        return ue_code(code_num);
    endfunction

    // Appends a word after the last valid bit. A word that does not fit
    // marks overflow, and once overflow is set the stream is frozen.
    function automatic stream_t append(input stream_t s, input vlc_t w);
        stream_t r;
        code_t   word;
        r    = s;
        word = code_t'(w.bits);
        if (s.overflow || (int'(s.len) + int'(w.len) > max_bits)) begin
            r.overflow = 1'b1;
        end else begin
            word   = word << (max_bits - int'(s.len) - int'(w.len));
            r.code = s.code | word;
            r.len  = s.len + len_t'(w.len);
        end
        return r;
    endfunction

endpackage

// File: design/cavlc_enc_top.sv
`timescale 1ns/1ns

module cavlc_enc_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  cavlc_pkg::block_t    in_block,
    output logic                 out_valid,
    input  logic                 out_ready,
    output bitstream_pkg::code_t out_code,
    output bitstream_pkg::len_t  out_len,
    output logic                 out_overflow,
    output cavlc_pkg::pos_t      out_x,
    output cavlc_pkg::pos_t      out_y
);

    cavlc_pkg::stage_t token_out;
    cavlc_pkg::stage_t level_out;
    cavlc_pkg::stage_t run_out;
    logic              token_valid;
    logic              token_ready;
    logic              level_valid;
    logic              level_ready;

    // coeff_token and trailing-one signs.
    cavlc_token_stage token_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_block  (in_block),
        .out_valid (token_valid),
        .out_ready (token_ready),
        .out_stage (token_out)
    );

    // Remaining levels.
    cavlc_level_stage level_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (token_valid),
        .in_ready  (token_ready),
        .in_stage  (token_out),
        .out_valid (level_valid),
        .out_ready (level_ready),
        .out_stage (level_out)
    );

    // total_zeros and run_before.
    cavlc_run_stage run_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (level_valid),
        .in_ready  (level_ready),
        .in_stage  (level_out),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_stage (run_out)
    );

    assign out_code     = run_out.stream.code;
    assign out_len      = run_out.stream.len;
    assign out_overflow = run_out.stream.overflow;
    assign out_x        = run_out.blk.topleft_x;
    assign out_y        = run_out.blk.topleft_y;

endmodule

// File: design/cavlc_level_stage.sv
`timescale 1ns/1ns

module cavlc_level_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  cavlc_pkg::stage_t in_stage,
    output logic              out_valid,
    input  logic              out_ready,
    output cavlc_pkg::stage_t out_stage
);

    typedef enum logic [1:0] {
        st_idle,
        st_encode,
        st_hold
    } state_t;

    state_t              state;
    cavlc_pkg::stage_t   cur;
    cavlc_pkg::count_t   idx;
    cavlc_pkg::count_t   num_levels;
    cavlc_pkg::count_t   in_levels;
    cavlc_pkg::level_t   level;
    logic                accept;
    logic                last_level;

    assign in_ready   = (state == st_idle);
    assign out_valid  = (state == st_hold);
    assign out_stage  = cur;
    assign accept     = in_valid && in_ready;
    assign in_levels  = cavlc_pkg::level_count(in_stage.blk);
    assign level      = cur.blk.levels[idx[3:0]];
    assign last_level = (idx + 5'd1 == num_levels);

    // ************************************************************************
    // Control. One level goes out per cycle in the encode state.
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            idx   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        idx <= '0;
                        if (in_levels == '0) begin
                            state <= st_hold;
                        end else begin
                            state <= st_encode;
                        end
                    end
                end
                st_encode: begin
                    idx <= idx + 5'd1;
                    if (last_level) begin
                        state <= st_hold;
                    end
                end
                st_hold: begin
                    if (out_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Payload and level count.
    always_ff @(posedge clk) begin
        if (accept) begin
            cur        <= in_stage;
            num_levels <= in_levels;
        end else if (state == st_encode) begin
            cur.stream <= bitstream_pkg::append(cur.stream, bitstream_pkg::se_code(level));
        end
    end

    // Trailing ones cover the unit magnitudes at the tail, so a zero level
    // means the upstream descriptor was malformed.
    a_level_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        (state == st_encode) |-> (level != '0)
    );

endmodule

// File: design/cavlc_pkg.sv
package cavlc_pkg;

    // ************************************************************************
    // Block descriptor of one 4x4 residual block.
    // ************************************************************************
    localparam int blk_size = 16;

    typedef logic [4:0]        count_t;
    typedef logic [1:0]        t1_t;
    typedef logic signed [7:0] level_t;
    typedef logic [4:0]        run_t;
    typedef logic [9:0]        pos_t;

    // Levels and runs are stored in writing order: levels[0] is the first
    // level after the trailing ones, runs[0] is the first run_before.
    // Bit i of t1_signs is the sign of trailing one i, 1 for negative.
    typedef struct packed {
        count_t                    total_coeff;
        t1_t                       trailing_ones;
        logic [2:0]                t1_signs;
        count_t                    total_zeros;
        level_t [blk_size-1:0]     levels;
        run_t [blk_size-1:0]       runs;
        pos_t                      topleft_x;
        pos_t                      topleft_y;
    } block_t;

    // What moves from one stage to the next: the descriptor and the
    // bitstream built so far.
    typedef struct packed {
        block_t                 blk;
        bitstream_pkg::stream_t stream;
    } stage_t;

    // Number of levels that are not trailing ones.
    function automatic count_t level_count(input block_t b);
        return b.total_coeff - count_t'(b.trailing_ones);
    endfunction

    // total_zeros is only sent for partially filled blocks.
    function automatic logic has_total_zeros(input block_t b);
        return (b.total_coeff != '0) && (int'(b.total_coeff) < blk_size);
    endfunction

    // Another run_before is due while zeros remain and the run index is
    // below total_coeff - 1.
    function automatic logic runs_pending(input block_t b, input count_t zeros_left,
                                          input count_t idx);
        return (zeros_left != '0) && (int'(idx) + 1 < int'(b.total_coeff));
    endfunction

endpackage

// File: design/cavlc_run_stage.sv
`timescale 1ns/1ns

module cavlc_run_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  cavlc_pkg::stage_t in_stage,
    output logic              out_valid,
    input  logic              out_ready,
    output cavlc_pkg::stage_t out_stage
);

    typedef enum logic [1:0] {
        st_idle,
        st_zeros,
        st_runs,
        st_hold
    } state_t;

    state_t              state;
    cavlc_pkg::stage_t   cur;
    cavlc_pkg::count_t   zeros_left;
    cavlc_pkg::count_t   idx;
    cavlc_pkg::count_t   zeros_next;
    cavlc_pkg::count_t   idx_next;
    cavlc_pkg::run_t     run;
    logic                accept;

    assign in_ready   = (state == st_idle);
    assign out_valid  = (state == st_hold);
    assign out_stage  = cur;
    assign accept     = in_valid && in_ready;
    assign run        = cur.blk.runs[idx[3:0]];
    assign zeros_next = zeros_left - run;
    assign idx_next   = idx + 5'd1;

    // ************************************************************************
    // Control. total_zeros takes one cycle when sent, then one cycle per
    // run_before. Blocks with nothing to send go straight to hold.
    // ************************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= st_idle;
            zeros_left <= '0;
            idx        <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        zeros_left <= in_stage.blk.total_zeros;
                        idx        <= '0;
                        if (cavlc_pkg::has_total_zeros(in_stage.blk)) begin
                            state <= st_zeros;
                        end else if (cavlc_pkg::runs_pending(in_stage.blk,
                                                             in_stage.blk.total_zeros,
                                                             '0)) begin
                            state <= st_runs;
                        end else begin
                            state <= st_hold;
                        end
                    end
                end
                st_zeros: begin
                    if (cavlc_pkg::runs_pending(cur.blk, zeros_left, idx)) begin
                        state <= st_runs;
                    end else begin
                        state <= st_hold;
                    end
                end
                st_runs: begin
                    zeros_left <= zeros_next;
                    idx        <= idx_next;
                    if (!cavlc_pkg::runs_pending(cur.blk, zeros_next, idx_next)) begin
                        state <= st_hold;
                    end
                end
                st_hold: begin
                    if (out_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur <= in_stage;
        end else if (state == st_zeros) begin
            cur.stream <= bitstream_pkg::append(cur.stream,
                bitstream_pkg::ue_code(15'(cur.blk.total_zeros)));
        end else if (state == st_runs) begin
            cur.stream <= bitstream_pkg::append(cur.stream, bitstream_pkg::ue_code(15'(run)));
        end
    end

    // Runs share out the zeros counted in total_zeros, so none can be
    // larger than what remains.
    a_run_fits: assert property (
        @(posedge clk) disable iff (rst)
        (state == st_runs) |-> (run <= zeros_left)
    );

endmodule

// File: design/cavlc_token_stage.sv
`timescale 1ns/1ns

module cavlc_token_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  cavlc_pkg::block_t in_block,
    output logic              out_valid,
    input  logic              out_ready,
    output cavlc_pkg::stage_t out_stage
);

    cavlc_pkg::stage_t      stage_q;
    bitstream_pkg::stream_t head;
    bitstream_pkg::vlc_t    sign_word;
    logic                   full;
    logic                   accept;

    // Single entry register stage, refilled in the cycle it drains.
    assign in_ready  = !full || out_ready;
    assign accept    = in_valid && in_ready;
    assign out_valid = full;
    assign out_stage = stage_q;

    // ************************************************************************
    // coeff_token is ue(total_coeff * 4 + trailing_ones), which is the
    // concatenation of both counts. One sign bit per trailing one follows.
    // ************************************************************************
    always_comb begin
        head      = '0;
        sign_word = '0;
        head = bitstream_pkg::append(head,
            bitstream_pkg::ue_code(15'({in_block.total_coeff, in_block.trailing_ones})));
        for (int i = 0; i < 3; i++) begin
            if (i < int'(in_block.trailing_ones)) begin
                sign_word.bits = 32'(in_block.t1_signs[i]);
                sign_word.len  = 6'd1;
                head = bitstream_pkg::append(head, sign_word);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_q.blk    <= in_block;
            stage_q.stream <= head;
        end
    end

    // A descriptor never claims more trailing ones than coefficients, nor
    // more coefficients than the block holds.
    a_legal_counts: assert property (
        @(posedge clk) disable iff (rst)
        accept |-> (cavlc_pkg::count_t'(in_block.trailing_ones) <= in_block.total_coeff)
               && (int'(in_block.total_coeff) <= cavlc_pkg::blk_size)
    );

    // A stalled descriptor stays offered and unchanged until it is taken.
    a_hold_stable: assert property (
        @(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> in_valid && $stable(in_block)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile the encoder and its testbench with Verilator, then run the simulation.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module cavlc_enc_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vcavlc_enc_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: src.f
+incdir+test
design/bitstream_pkg.sv
design/cavlc_pkg.sv
design/cavlc_token_stage.sv
design/cavlc_level_stage.sv
design/cavlc_run_stage.sv
design/cavlc_enc_top.sv
test/cavlc_enc_tb.sv

// File: test/cavlc_ref_model.svh
// ****************************************************************************
// Reference CAVLC stream, built one bit at a time from the syntax rules.
// ****************************************************************************

// A word of nbits goes in whole or not at all. Once a word did not fit, the
// stream stays frozen with overflow set.
function automatic bitstream_pkg::stream_t add_word(input bitstream_pkg::stream_t s,
                                                   input logic [31:0] value,
                                                   input int nbits);
    bitstream_pkg::stream_t r;
    r = s;
    if (r.overflow || (int'(r.len) + nbits > bitstream_pkg::max_bits)) begin
        r.overflow = 1'b1;
    end else begin
        for (int i = nbits - 1; i >= 0; i--) begin
            r.code[bitstream_pkg::max_bits - 1 - int'(r.len)] = value[i];
            r.len = r.len + 8'd1;
        end
    end
    return r;
endfunction

// ue(k): as many zeros as value k + 1 has bits after its leading one,
// then k + 1 itself.
function automatic bitstream_pkg::stream_t add_ue(input bitstream_pkg::stream_t s,
                                                 input int value);
    logic [31:0] x;
    int          nb;
    x  = 32'(value + 1);
    nb = 0;
    for (int i = 0; i < 32; i++) begin
        if (x[i]) begin
            nb = i + 1;
        end
    end
    return add_word(s, x, 2 * nb - 1);
endfunction

function automatic bitstream_pkg::stream_t add_se(input bitstream_pkg::stream_t s,
                                                 input int level);
    return add_ue(s, (level > 0) ? (2 * level - 1) : (-2 * level));
endfunction

function automatic bitstream_pkg::stream_t expected_stream(input cavlc_pkg::block_t b);
    bitstream_pkg::stream_t s;
    cavlc_pkg::level_t      lv;
    int                     tc;
    int                     t1;
    int                     zl;
    s  = '0;
    tc = int'(b.total_coeff);
    t1 = int'(b.trailing_ones);
    s  = add_ue(s, tc * 4 + t1);
    for (int i = 0; i < t1; i++) begin
        s = add_word(s, 32'(b.t1_signs[i]), 1);
    end
    for (int i = 0; i < tc - t1; i++) begin
        lv = b.levels[i];
        s  = add_se(s, int'(lv));
    end
    if (tc >= 1 && tc <= 15) begin
        s = add_ue(s, int'(b.total_zeros));
    end
    zl = int'(b.total_zeros);
    for (int i = 0; i <= tc - 2 && zl > 0; i++) begin
        s  = add_ue(s, int'(b.runs[i]));
        zl = zl - int'(b.runs[i]);
    end
    return s;
endfunction

// File: test/cavlc_enc_tb.sv
`timescale 1ns/1ns

module cavlc_enc_tb;

    localparam int num_directed = 19;
    localparam int num_random   = 60;
    localparam int num_blocks   = num_directed + num_random;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 in_valid;
    logic                 in_ready;
    cavlc_pkg::block_t    in_block;
    logic                 out_valid;
    logic                 out_ready;
    bitstream_pkg::code_t out_code;
    bitstream_pkg::len_t  out_len;
    logic                 out_overflow;
    cavlc_pkg::pos_t      out_x;
    cavlc_pkg::pos_t      out_y;

    cavlc_pkg::block_t    expected_q[$];
    int                   sent = 0;
    int                   received = 0;

    cavlc_enc_top uut (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_block     (in_block),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_code     (out_code),
        .out_len      (out_len),
        .out_overflow (out_overflow),
        .out_x        (out_x),
        .out_y        (out_y)
    );

    `include "cavlc_ref_model.svh"

    always #10 clk = ~clk;

    task automatic check(input string name, input logic [127:0] got,
                         input logic [127:0] want);
        if (got !== want) begin
            $display("** Error %s: got 0x%h, expected 0x%h", name, got, want);
            $display("tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Called 2 ns after a rising edge. Ready is sampled at the falling edge,
    // where nothing changes until the next rising edge.
    task automatic send_block(input cavlc_pkg::block_t b);
        logic taken;
        taken    = 1'b0;
        in_valid = 1'b1;
        in_block = b;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #2;
        end
        expected_q.push_back(b);
        sent++;
        in_valid = 1'b0;
    endtask

    // Shares total_zeros out over the runs, never more than what is left.
    function automatic cavlc_pkg::block_t spread_runs(input cavlc_pkg::block_t b);
        cavlc_pkg::block_t r;
        int                zl;
        int                run;
        r  = b;
        zl = int'(b.total_zeros);
        for (int i = 0; i < int'(b.total_coeff) - 1; i++) begin
            run       = int'($urandom_range(0, zl));
            r.runs[i] = cavlc_pkg::run_t'(run);
            zl        = zl - run;
        end
        return r;
    endfunction

    function automatic cavlc_pkg::block_t random_block();
        cavlc_pkg::block_t b;
        int                tc;
        int                t1;
        int                mag;
        b               = '0;
        tc              = int'($urandom_range(0, 16));
        t1              = int'($urandom_range(0, (tc < 3) ? tc : 3));
        b.total_coeff   = cavlc_pkg::count_t'(tc);
        b.trailing_ones = cavlc_pkg::t1_t'(t1);
        b.t1_signs      = 3'($urandom_range(0, 7));
        for (int i = 0; i < tc - t1; i++) begin
            mag         = int'($urandom_range(1, 6));
            b.levels[i] = cavlc_pkg::level_t'(($urandom_range(0, 1) == 1) ? -mag : mag);
        end
        if (tc > 0) begin
            b.total_zeros = cavlc_pkg::count_t'($urandom_range(0, 16 - tc));
        end
        b.topleft_x = cavlc_pkg::pos_t'($urandom_range(0, 1023));
        b.topleft_y = cavlc_pkg::pos_t'($urandom_range(0, 1023));
        return spread_runs(b);
    endfunction

    // ************************************************************************
    // Stimulus.
    // ************************************************************************
    initial begin
        cavlc_pkg::block_t b;
        int                gap;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_block = '0;
        void'($urandom(32'hb2e11e11));
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;
        check("out_valid", 128'(out_valid), 128'(1'b0));
        check("in_ready", 128'(in_ready), 128'(1'b1));

        // Empty block.
        b           = '0;
        b.topleft_x = 10'd4;
        send_block(b);

        // Trailing ones only, every sign pattern.
        for (int t1 = 1; t1 <= 3; t1++) begin
            for (int s = 0; s < (1 << t1); s++) begin
                b               = '0;
                b.total_coeff   = cavlc_pkg::count_t'(t1);
                b.trailing_ones = cavlc_pkg::t1_t'(t1);
                b.t1_signs      = 3'(s);
                b.total_zeros   = cavlc_pkg::count_t'(t1);
                b.topleft_x     = cavlc_pkg::pos_t'(4 * s);
                b.topleft_y     = cavlc_pkg::pos_t'(4 * t1);
                send_block(spread_runs(b));
            end
        end

        // Full block, so no total_zeros.
        b               = '0;
        b.total_coeff   = 5'd16;
        b.trailing_ones = 2'd1;
        for (int i = 0; i < 15; i++) begin
            b.levels[i] = cavlc_pkg::level_t'((i % 2 == 1) ? -(i % 3 + 1) : (i % 3 + 1));
        end
        send_block(b);

        // The first run uses up every zero, so the second is never written.
        b             = '0;
        b.total_coeff = 5'd6;
        for (int i = 0; i < 6; i++) begin
            b.levels[i] = cavlc_pkg::level_t'(i + 1);
        end
        b.total_zeros = 5'd4;
        b.runs[0]     = 5'd4;
        b.runs[1]     = 5'd3;
        send_block(b);

        // Large levels run past the 128-bit limit.
        b             = '0;
        b.total_coeff = 5'd16;
        for (int i = 0; i < 16; i++) begin
            b.levels[i] = (i % 2 == 1) ? -8'sd121 : 8'sd120;
        end
        send_block(b);
        b               = '0;
        b.total_coeff   = 5'd10;
        b.trailing_ones = 2'd2;
        b.t1_signs      = 3'b001;
        b.total_zeros   = 5'd6;
        for (int i = 0; i < 8; i++) begin
            b.levels[i] = (i % 2 == 1) ? 8'sd100 : -8'sd100;
        end
        send_block(spread_runs(b));

        for (int n = 0; n < num_random; n++) begin
            gap = int'($urandom_range(0, 2));
            repeat (gap) begin
                @(posedge clk);
                #2;
            end
            send_block(random_block());
        end

        wait (received == sent);
        repeat (20) @(posedge clk);
        if (received == num_blocks && expected_q.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("Block count out of step: %0d sent, %0d received.", sent, received);
            $display("tests failed");
            $fatal(1, "block count mismatch");
        end
    end

    // Output back-pressure.
    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (rst) begin
                out_ready = 1'b0;
            end else begin
                out_ready = ($urandom_range(0, 3) != 0);
            end
        end
    end

    // A transfer seen at the falling edge completes on the next rising edge.
    initial begin
        cavlc_pkg::block_t      blk;
        bitstream_pkg::stream_t want;
        forever begin
            @(negedge clk);
            if (!rst && out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    $display("An output transfer arrived with no block pending.");
                    $display("tests failed");
                    $fatal(1, "unexpected output");
                end else begin
                    blk  = expected_q.pop_front();
                    want = expected_stream(blk);
                    check("out_code", out_code, want.code);
                    check("out_len", 128'(out_len), 128'(want.len));
                    check("out_overflow", 128'(out_overflow), 128'(want.overflow));
                    check("out_x", 128'(out_x), 128'(blk.topleft_x));
                    check("out_y", 128'(out_y), 128'(blk.topleft_y));
                    received++;
                end
            end
        end
    end

    initial begin
        repeat (200 * num_blocks + 8) @(posedge clk);
        $display("Timeout: not every block came out within %0d cycles.", 200 * num_blocks);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule
